/* common/lsq_pkg.sv */
package lsq_pkg;

    // ==================================================
    // Widths
    // ==================================================

    // Reorder buffer index width
    localparam int ROB_IDX_WIDTH = 5;
    // Byte address width
    localparam int ADDR_WIDTH = 32;
    // Only word accesses remain
    localparam int DATA_WIDTH = 32;

    // ==================================================
    // Word types
    // ==================================================

    typedef logic [ROB_IDX_WIDTH-1:0] rob_idx_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;

    // ==================================================
    // Cache command encoding
    // ==================================================

    typedef enum logic [1:0] {
        MEM_NONE  = 2'b00,
        MEM_LOAD  = 2'b01,
        MEM_STORE = 2'b10
    } mem_command_t;

endpackage

/* lsq/store_queue.sv */
`timescale 1ns/100ps

module store_queue import lsq_pkg::*; #(
    parameter int SQ_SIZE = 8
) (
    input  logic     clock,
    input  logic     reset,
    // Enqueue from dispatch
    input  logic     enq_valid_i,
    input  rob_idx_t enq_rob_idx_i,
    output logic     full_o,
    // Execution update
    input  logic     exec_valid_i,
    input  rob_idx_t exec_rob_idx_i,
    input  addr_t    exec_addr_i,
    input  data_t    exec_data_i,
    // Commit side
    input  rob_idx_t rob_head_i,
    input  logic     commit_valid_i,
    input  rob_idx_t commit_rob_idx_i,
    // Store port request
    output logic     req_valid_o,
    output addr_t    req_addr_o,
    output data_t    req_data_o,
    output rob_idx_t req_rob_idx_o,
    input  logic     req_accept_i,
    // Store-ready notice to ROB
    output logic     store_ready_valid_o,
    output rob_idx_t store_ready_idx_o,
    // Head info for load ordering
    output logic     oldest_valid_o,
    output rob_idx_t oldest_rob_idx_o
);

    localparam int PTR_W = $clog2(SQ_SIZE);
    localparam int CNT_W = $clog2(SQ_SIZE + 1);

    // Circular buffer pointers
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [CNT_W-1:0] count_q;

    // Per-entry flags
    logic [SQ_SIZE-1:0] valid_q;
    logic [SQ_SIZE-1:0] addr_known_q;
    logic [SQ_SIZE-1:0] data_known_q;
    logic [SQ_SIZE-1:0] committed_q;

    // Per-entry payload
    rob_idx_t rob_idx_q [SQ_SIZE];
    addr_t    addr_q [SQ_SIZE];
    data_t    data_q [SQ_SIZE];

    logic               enq_fire;
    logic               deq_fire;
    logic [SQ_SIZE-1:0] exec_match;
    logic [SQ_SIZE-1:0] commit_match;
    logic               exec_completes;

    // ==================================================
    // Entry lookup by ROB index
    // ==================================================
    always_comb begin
        exec_match     = '0;
        commit_match   = '0;
        exec_completes = 1'b0;
        for (int i = 0; i < SQ_SIZE; i++) begin
            // Committed entries are frozen
            exec_match[i] = exec_valid_i && valid_q[i] && !committed_q[i]
                            && (rob_idx_q[i] == exec_rob_idx_i);
            commit_match[i] = commit_valid_i && valid_q[i] && !committed_q[i]
                              && (rob_idx_q[i] == commit_rob_idx_i);
            // First update that completes the store
            if (exec_match[i] && !(addr_known_q[i] && data_known_q[i])) begin
                exec_completes = 1'b1;
            end
        end
    end

    assign full_o   = (count_q == CNT_W'(SQ_SIZE));
    assign enq_fire = enq_valid_i && !full_o;

    // Head drains once committed and complete
    assign req_valid_o = valid_q[head_q] && committed_q[head_q]
                         && addr_known_q[head_q] && data_known_q[head_q];
    assign deq_fire      = req_valid_o && req_accept_i;
    assign req_addr_o    = addr_q[head_q];
    assign req_data_o    = data_q[head_q];
    assign req_rob_idx_o = rob_idx_q[head_q];

    // A committed head already left the ROB
    // Report it at rob_head so every pending load sees it as older
    assign oldest_valid_o   = valid_q[head_q];
    assign oldest_rob_idx_o = committed_q[head_q] ? rob_head_i : rob_idx_q[head_q];

    // ==================================================
    // Control state
    // ==================================================
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            head_q              <= '0;
            tail_q              <= '0;
            count_q             <= '0;
            valid_q             <= '0;
            addr_known_q        <= '0;
            data_known_q        <= '0;
            committed_q         <= '0;
            store_ready_valid_o <= 1'b0;
        end else begin
            // New store at tail
            if (enq_fire) begin
                valid_q[tail_q]      <= 1'b1;
                addr_known_q[tail_q] <= 1'b0;
                data_known_q[tail_q] <= 1'b0;
                committed_q[tail_q]  <= 1'b0;
                tail_q               <= tail_q + 1'b1;
            end
            // Address and data arrive together
            for (int i = 0; i < SQ_SIZE; i++) begin
                if (exec_match[i]) begin
                    addr_known_q[i] <= 1'b1;
                    data_known_q[i] <= 1'b1;
                end
                if (commit_match[i]) begin
                    committed_q[i] <= 1'b1;
                end
            end
            // Head leaves on transfer
            if (deq_fire) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= head_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(enq_fire) - CNT_W'(deq_fire);
            // One pulse per store
            store_ready_valid_o <= exec_completes;
        end
    end

    // Payload writes
    always_ff @(posedge clock) begin
        if (enq_fire) begin
            rob_idx_q[tail_q] <= enq_rob_idx_i;
        end
        for (int i = 0; i < SQ_SIZE; i++) begin
            if (exec_match[i]) begin
                addr_q[i] <= exec_addr_i;
                data_q[i] <= exec_data_i;
            end
        end
        if (exec_completes) begin
            store_ready_idx_o <= exec_rob_idx_i;
        end
    end

endmodule

/* lsq/load_queue.sv */
`timescale 1ns/100ps

module load_queue import lsq_pkg::*; #(
    parameter int LQ_SIZE = 8
) (
    input  logic     clock,
    input  logic     reset,
    // Enqueue from dispatch
    input  logic     enq_valid_i,
    input  rob_idx_t enq_rob_idx_i,
    output logic     full_o,
    // Address update
    input  logic     exec_valid_i,
    input  rob_idx_t exec_rob_idx_i,
    input  addr_t    exec_addr_i,
    // Ordering against stores
    input  rob_idx_t rob_head_i,
    input  logic     sq_oldest_valid_i,
    input  rob_idx_t sq_oldest_rob_idx_i,
    // Load port request
    output logic     req_valid_o,
    output addr_t    req_addr_o,
    output rob_idx_t req_rob_idx_o,
    input  logic     req_accept_i,
    // Load port response
    input  logic     resp_valid_i,
    input  data_t    resp_data_i,
    input  rob_idx_t resp_rob_idx_i,
    // Writeback
    output logic     wb_valid_o,
    output rob_idx_t wb_rob_idx_o,
    output data_t    wb_data_o
);

    localparam int PTR_W = $clog2(LQ_SIZE);
    localparam int CNT_W = $clog2(LQ_SIZE + 1);

    // Head retires, issue walks forward, tail allocates
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] issue_q;
    logic [PTR_W-1:0] tail_q;
    logic [CNT_W-1:0] count_q;

    // Per-entry flags
    logic [LQ_SIZE-1:0] valid_q;
    logic [LQ_SIZE-1:0] addr_known_q;
    logic [LQ_SIZE-1:0] issued_q;
    logic [LQ_SIZE-1:0] done_q;

    // Per-entry payload
    rob_idx_t rob_idx_q [LQ_SIZE];
    addr_t    addr_q [LQ_SIZE];

    logic               enq_fire;
    logic               issue_fire;
    logic               retire;
    logic               older_store;
    rob_idx_t           ld_age;
    rob_idx_t           st_age;
    logic [LQ_SIZE-1:0] exec_match;
    logic [LQ_SIZE-1:0] resp_match;
    logic               resp_hit;

    // ==================================================
    // Entry lookup by ROB index
    // ==================================================
    always_comb begin
        exec_match = '0;
        resp_match = '0;
        for (int i = 0; i < LQ_SIZE; i++) begin
            // Address only useful before issue
            exec_match[i] = exec_valid_i && valid_q[i] && !issued_q[i]
                            && (rob_idx_q[i] == exec_rob_idx_i);
            // Response goes to the in-flight load
            resp_match[i] = resp_valid_i && valid_q[i] && issued_q[i] && !done_q[i]
                            && (rob_idx_q[i] == resp_rob_idx_i);
        end
    end

    assign resp_hit = |resp_match;

    assign full_o   = (count_q == CNT_W'(LQ_SIZE));
    assign enq_fire = enq_valid_i && !full_o;

    // Age as distance from the ROB head, mod index space
    assign ld_age = rob_idx_q[issue_q] - rob_head_i;
    assign st_age = sq_oldest_rob_idx_i - rob_head_i;
    // Conservative ordering
    // Any store at or before the load blocks it
    assign older_store = sq_oldest_valid_i && (st_age <= ld_age);

    // In-order issue from the issue pointer
    assign req_valid_o = valid_q[issue_q] && !issued_q[issue_q]
                         && addr_known_q[issue_q] && !older_store;
    assign issue_fire    = req_valid_o && req_accept_i;
    assign req_addr_o    = addr_q[issue_q];
    assign req_rob_idx_o = rob_idx_q[issue_q];

    // Written-back load leaves from head
    assign retire = valid_q[head_q] && done_q[head_q];

    // ==================================================
    // Control state
    // ==================================================
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            head_q       <= '0;
            issue_q      <= '0;
            tail_q       <= '0;
            count_q      <= '0;
            valid_q      <= '0;
            addr_known_q <= '0;
            issued_q     <= '0;
            done_q       <= '0;
            wb_valid_o   <= 1'b0;
        end else begin
            if (enq_fire) begin
                valid_q[tail_q]      <= 1'b1;
                addr_known_q[tail_q] <= 1'b0;
                issued_q[tail_q]     <= 1'b0;
                done_q[tail_q]       <= 1'b0;
                tail_q               <= tail_q + 1'b1;
            end
            for (int i = 0; i < LQ_SIZE; i++) begin
                if (exec_match[i]) begin
                    addr_known_q[i] <= 1'b1;
                end
                if (resp_match[i]) begin
                    done_q[i] <= 1'b1;
                end
            end
            // Several loads may be in flight
            if (issue_fire) begin
                issued_q[issue_q] <= 1'b1;
                issue_q           <= issue_q + 1'b1;
            end
            if (retire) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= head_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(enq_fire) - CNT_W'(retire);
            // Writeback one cycle after response
            wb_valid_o <= resp_hit;
        end
    end

    // Payload writes
    always_ff @(posedge clock) begin
        if (enq_fire) begin
            rob_idx_q[tail_q] <= enq_rob_idx_i;
        end
        for (int i = 0; i < LQ_SIZE; i++) begin
            if (exec_match[i]) begin
                addr_q[i] <= exec_addr_i;
            end
        end
        if (resp_hit) begin
            wb_rob_idx_o <= resp_rob_idx_i;
            wb_data_o    <= resp_data_i;
        end
    end

endmodule

/* verilog/lsq_top.sv */
`timescale 1ns/100ps

module lsq_top import lsq_pkg::*; #(
    parameter int SQ_SIZE = 8,
    parameter int LQ_SIZE = 8
) (
    input  logic         clock,
    input  logic         reset,
    // Dispatch
    input  logic         dispatch_valid_i,
    input  logic         dispatch_is_store_i,
    input  rob_idx_t     dispatch_rob_idx_i,
    output logic         lsq_full_o,
    // Execution broadcast
    input  logic         exec_valid_i,
    input  rob_idx_t     exec_rob_idx_i,
    input  addr_t        exec_addr_i,
    input  data_t        exec_data_i,
    // Commit
    input  rob_idx_t     rob_head_i,
    input  logic         commit_valid_i,
    input  rob_idx_t     commit_rob_idx_i,
    // Writeback
    output logic         wb_valid_o,
    output rob_idx_t     wb_rob_idx_o,
    output data_t        wb_data_o,
    // Port 0 for loads
    output mem_command_t dcache_command_0_o,
    output addr_t        dcache_addr_0_o,
    output rob_idx_t     dcache_rob_idx_0_o,
    input  logic         dcache_accept_0_i,
    input  logic         dcache_valid_0_i,
    input  data_t        dcache_data_0_i,
    input  rob_idx_t     dcache_rob_idx_0_i,
    // Port 1 for stores
    output mem_command_t dcache_command_1_o,
    output addr_t        dcache_addr_1_o,
    output data_t        dcache_data_1_o,
    output rob_idx_t     dcache_rob_idx_1_o,
    input  logic         dcache_accept_1_i,
    // Store-ready notice
    output logic         rob_store_ready_valid_o,
    output rob_idx_t     rob_store_ready_idx_o
);

    logic     sq_full;
    logic     lq_full;
    logic     sq_enq_valid;
    logic     lq_enq_valid;
    logic     new_dispatch;
    logic     dispatch_accept;
    logic     sq_oldest_valid;
    rob_idx_t sq_oldest_rob_idx;
    logic     store_req_valid;
    logic     load_req_valid;

    // Last index seen while valid is held
    rob_idx_t last_rob_idx_q;
    logic     last_seen_q;

    // ==================================================
    // Dispatch filter and steering
    // ==================================================

    // Repeat of a held dispatch counts only once
    assign new_dispatch = dispatch_valid_i
                          && !(last_seen_q && (dispatch_rob_idx_i == last_rob_idx_q));

    // Stall on the targeted queue
    assign lsq_full_o      = dispatch_is_store_i ? sq_full : lq_full;
    assign dispatch_accept = new_dispatch && !lsq_full_o;
    assign sq_enq_valid    = dispatch_accept && dispatch_is_store_i;
    assign lq_enq_valid    = dispatch_accept && !dispatch_is_store_i;

    // Recorded only when taken, so a stalled dispatch retries
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            last_rob_idx_q <= '0;
            last_seen_q    <= 1'b0;
        end else if (!dispatch_valid_i) begin
            // Valid dropped so the next index is fresh
            last_seen_q <= 1'b0;
        end else if (!lsq_full_o) begin
            last_rob_idx_q <= dispatch_rob_idx_i;
            last_seen_q    <= 1'b1;
        end
    end

    store_queue #(
        .SQ_SIZE(SQ_SIZE)
    ) sq0 (
        .clock               (clock),
        .reset               (reset),
        .enq_valid_i         (sq_enq_valid),
        .enq_rob_idx_i       (dispatch_rob_idx_i),
        .full_o              (sq_full),
        .exec_valid_i        (exec_valid_i),
        .exec_rob_idx_i      (exec_rob_idx_i),
        .exec_addr_i         (exec_addr_i),
        .exec_data_i         (exec_data_i),
        .rob_head_i          (rob_head_i),
        .commit_valid_i      (commit_valid_i),
        .commit_rob_idx_i    (commit_rob_idx_i),
        .req_valid_o         (store_req_valid),
        .req_addr_o          (dcache_addr_1_o),
        .req_data_o          (dcache_data_1_o),
        .req_rob_idx_o       (dcache_rob_idx_1_o),
        .req_accept_i        (dcache_accept_1_i),
        .store_ready_valid_o (rob_store_ready_valid_o),
        .store_ready_idx_o   (rob_store_ready_idx_o),
        .oldest_valid_o      (sq_oldest_valid),
        .oldest_rob_idx_o    (sq_oldest_rob_idx)
    );

    load_queue #(
        .LQ_SIZE(LQ_SIZE)
    ) lq0 (
        .clock               (clock),
        .reset               (reset),
        .enq_valid_i         (lq_enq_valid),
        .enq_rob_idx_i       (dispatch_rob_idx_i),
        .full_o              (lq_full),
        .exec_valid_i        (exec_valid_i),
        .exec_rob_idx_i      (exec_rob_idx_i),
        .exec_addr_i         (exec_addr_i),
        .rob_head_i          (rob_head_i),
        .sq_oldest_valid_i   (sq_oldest_valid),
        .sq_oldest_rob_idx_i (sq_oldest_rob_idx),
        .req_valid_o         (load_req_valid),
        .req_addr_o          (dcache_addr_0_o),
        .req_rob_idx_o       (dcache_rob_idx_0_o),
        .req_accept_i        (dcache_accept_0_i),
        .resp_valid_i        (dcache_valid_0_i),
        .resp_data_i         (dcache_data_0_i),
        .resp_rob_idx_i      (dcache_rob_idx_0_i),
        .wb_valid_o          (wb_valid_o),
        .wb_rob_idx_o        (wb_rob_idx_o),
        .wb_data_o           (wb_data_o)
    );

    // ==================================================
    // Cache command encoding
    // ==================================================
    assign dcache_command_0_o = load_req_valid ? MEM_LOAD : MEM_NONE;
    assign dcache_command_1_o = store_req_valid ? MEM_STORE : MEM_NONE;

endmodule

/* test/lsq_checker.sv */
`timescale 1ns/100ps

module lsq_checker import lsq_pkg::*; (
    input logic         clock,
    input logic         reset,
    input logic         wb_valid_i,
    input logic         store_ready_valid_i,
    input logic         lsq_full_i,
    input mem_command_t command_0_i,
    input addr_t        addr_0_i,
    input rob_idx_t     rob_idx_0_i,
    input logic         accept_0_i,
    input mem_command_t command_1_i,
    input addr_t        addr_1_i,
    input data_t        data_1_i,
    input rob_idx_t     rob_idx_1_i,
    input logic         accept_1_i
);

    // ==================================================
    // Reset state
    // ==================================================
    reset_quiet: assert property (@(posedge clock) reset |-> (!wb_valid_i && !store_ready_valid_i
            && command_0_i == MEM_NONE && command_1_i == MEM_NONE && !lsq_full_i))
        else $error("Outputs not idle while reset is held");

    // ==================================================
    // Request held steady under back-pressure
    // ==================================================
    store_hold: assert property (@(posedge clock) disable iff (reset)
            (command_1_i == MEM_STORE && !accept_1_i) |=> (command_1_i == MEM_STORE
            && $stable(addr_1_i) && $stable(data_1_i) && $stable(rob_idx_1_i)))
        else $error("Store request changed while not accepted");

    load_hold: assert property (@(posedge clock) disable iff (reset)
            (command_0_i == MEM_LOAD && !accept_0_i) |=> (command_0_i == MEM_LOAD
            && $stable(addr_0_i) && $stable(rob_idx_0_i)))
        else $error("Load request changed while not accepted");

endmodule

bind lsq_top lsq_checker chk0 (
    .clock               (clock),
    .reset               (reset),
    .wb_valid_i          (wb_valid_o),
    .store_ready_valid_i (rob_store_ready_valid_o),
    .lsq_full_i          (lsq_full_o),
    .command_0_i         (dcache_command_0_o),
    .addr_0_i            (dcache_addr_0_o),
    .rob_idx_0_i         (dcache_rob_idx_0_o),
    .accept_0_i          (dcache_accept_0_i),
    .command_1_i         (dcache_command_1_o),
    .addr_1_i            (dcache_addr_1_o),
    .data_1_i            (dcache_data_1_o),
    .rob_idx_1_i         (dcache_rob_idx_1_o),
    .accept_1_i          (dcache_accept_1_i)
);

/* test/lsq_tb.sv */
`timescale 1ns/100ps

module lsq_tb import lsq_pkg::*;;

    localparam int CLK_PERIOD  = 20;
    localparam int N_TESTS     = 6;
    localparam int TEST_CYCLES = 300;
    localparam int WATCHDOG_NS = (N_TESTS * TEST_CYCLES + 100) * CLK_PERIOD;

    logic clock = 1'b0;
    logic reset;
    logic dispatch_valid, dispatch_is_store, exec_valid, commit_valid;
    logic accept0, accept1, resp_valid;
    rob_idx_t dispatch_idx, exec_idx, rob_head, commit_idx, resp_idx;
    addr_t exec_addr;
    data_t exec_data, resp_data;
    logic lsq_full, wb_valid, ready_valid;
    rob_idx_t wb_idx, req0_idx, req1_idx, ready_idx;
    data_t wb_data, req1_data;
    addr_t req0_addr, req1_addr;
    mem_command_t cmd0, cmd1;

    // Scoreboard indexed by ROB index
    logic  load_pending [32];
    logic  committed [32];
    logic  ready_due [32];
    data_t load_exp [32];
    addr_t ld_addr [32];
    addr_t st_addr [32];
    data_t st_data [32];
    int    issue_cnt [32];
    int    wb_cnt [32];
    rob_idx_t store_order [$];
    int    outstanding, ready_cnt, stores_total, errors, pass_cnt, fail_cnt, errs0;
    rob_idx_t next_idx;

    // Memory model and in-flight load responses
    data_t    mem [addr_t];
    rob_idx_t rsp_idx [$];
    data_t    rsp_data [$];
    int       rsp_wait [$];
    logic [15:0] lfsr_q = 16'd58;

    lsq_top dut0 (
        .clock(clock), .reset(reset),
        .dispatch_valid_i(dispatch_valid), .dispatch_is_store_i(dispatch_is_store),
        .dispatch_rob_idx_i(dispatch_idx), .lsq_full_o(lsq_full),
        .exec_valid_i(exec_valid), .exec_rob_idx_i(exec_idx),
        .exec_addr_i(exec_addr), .exec_data_i(exec_data),
        .rob_head_i(rob_head), .commit_valid_i(commit_valid), .commit_rob_idx_i(commit_idx),
        .wb_valid_o(wb_valid), .wb_rob_idx_o(wb_idx), .wb_data_o(wb_data),
        .dcache_command_0_o(cmd0), .dcache_addr_0_o(req0_addr), .dcache_rob_idx_0_o(req0_idx),
        .dcache_accept_0_i(accept0), .dcache_valid_0_i(resp_valid),
        .dcache_data_0_i(resp_data), .dcache_rob_idx_0_i(resp_idx),
        .dcache_command_1_o(cmd1), .dcache_addr_1_o(req1_addr), .dcache_data_1_o(req1_data),
        .dcache_rob_idx_1_o(req1_idx), .dcache_accept_1_i(accept1),
        .rob_store_ready_valid_o(ready_valid), .rob_store_ready_idx_o(ready_idx)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    // Galois LFSR stepped once per bit
    function automatic logic take_bit();
        logic b;
        b = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (b) lfsr_q = lfsr_q ^ 16'hB400;
        return b;
    endfunction

    function automatic data_t mem_read(addr_t a);
        return mem.exists(a) ? mem[a] : ~a;
    endfunction

    task automatic report_err(input string msg);
        errors++;
        $display("ERR %0t %s", $time, msg);
    endtask

    // ==================================================
    // Cache model with random accept and response delay
    // ==================================================
    always @(posedge clock) begin : drive_cache
        int pick;
        accept0 <= take_bit() | take_bit();
        accept1 <= take_bit() | take_bit();
        pick = -1;
        for (int i = 0; i < rsp_wait.size(); i++) begin
            if (rsp_wait[i] < 0) rsp_wait[i] = {take_bit(), take_bit(), take_bit()};
            else if (rsp_wait[i] > 0) rsp_wait[i]--;
            else if (pick < 0) pick = i;
        end
        // Short waits overtake older loads
        if (pick >= 0) begin
            resp_valid <= 1'b1;
            resp_idx   <= rsp_idx[pick];
            resp_data  <= rsp_data[pick];
            rsp_idx.delete(pick);
            rsp_data.delete(pick);
            rsp_wait.delete(pick);
        end else begin
            resp_valid <= 1'b0;
        end
    end

    // ==================================================
    // Output checks sampled mid-cycle
    // ==================================================
    always @(negedge clock) begin : check_outputs
        rob_idx_t s;
        if (!reset) begin
            if (wb_valid) begin
                assert (load_pending[wb_idx]) else report_err("writeback for no pending load");
                assert (wb_data == load_exp[wb_idx])
                    else report_err($sformatf("load %0d data %h", wb_idx, wb_data));
                load_pending[wb_idx] = 1'b0;
                wb_cnt[wb_idx]++;
                outstanding--;
            end
            if (ready_valid) begin
                assert (ready_due[ready_idx]) else report_err("unexpected store-ready pulse");
                ready_due[ready_idx] = 1'b0;
                ready_cnt++;
            end
            // Transfer happens at the coming edge
            if (cmd1 == MEM_STORE && accept1) begin
                s = store_order.size() > 0 ? store_order[0] : ~req1_idx;
                assert (req1_idx == s) else report_err("store out of dispatch order");
                assert (committed[req1_idx]) else report_err("store sent before commit");
                assert (req1_addr == st_addr[req1_idx] && req1_data == st_data[req1_idx])
                    else report_err("store address or data wrong");
                mem[req1_addr] = req1_data;
                if (store_order.size() > 0) void'(store_order.pop_front());
            end
            if (cmd0 == MEM_LOAD && accept0) begin
                assert (load_pending[req0_idx] && issue_cnt[req0_idx] == 0)
                    else report_err("load request repeated or unknown");
                assert (req0_addr == ld_addr[req0_idx]) else report_err("load address wrong");
                issue_cnt[req0_idx]++;
                rsp_idx.push_back(req0_idx);
                rsp_data.push_back(mem_read(req0_addr));
                rsp_wait.push_back(-1);
            end
        end
    end

    // ==================================================
    // Stimulus tasks
    // ==================================================
    task automatic dispatch(input logic is_store, input rob_idx_t idx, input int hold);
        int c;
        if (is_store) begin
            store_order.push_back(idx);
            stores_total++;
        end else begin
            load_pending[idx] = 1'b1;
            outstanding++;
        end
        @(posedge clock);
        dispatch_valid <= 1'b1;
        dispatch_is_store <= is_store;
        dispatch_idx <= idx;
        c = 0;
        @(negedge clock);
        while (lsq_full && c < TEST_CYCLES) begin
            @(negedge clock);
            c++;
        end
        if (lsq_full) begin
            errors++;
            $display("Dispatch of index %0d stalled too long", idx);
        end
        repeat (hold) @(posedge clock);
        dispatch_valid <= 1'b0;
    endtask

    task automatic execute(input logic is_store, input rob_idx_t idx, input addr_t a,
                           input data_t d);
        if (is_store) begin
            st_addr[idx] = a;
            st_data[idx] = d;
        end else begin
            ld_addr[idx] = a;
        end
        @(posedge clock);
        exec_valid <= 1'b1;
        exec_idx <= idx;
        exec_addr <= a;
        exec_data <= d;
        @(posedge clock);
        exec_valid <= 1'b0;
        // Update taken at this edge so the ready pulse may follow
        if (is_store) begin
            ready_due[idx] = 1'b1;
        end
    endtask

    task automatic commit(input rob_idx_t idx);
        @(posedge clock);
        commit_valid <= 1'b1;
        commit_idx <= idx;
        @(posedge clock);
        commit_valid <= 1'b0;
        // Commit marked at this edge
        committed[idx] = 1'b1;
    endtask

    task automatic start_test();
        errs0 = errors;
        @(posedge clock);
        rob_head <= next_idx;
    endtask

    task automatic wait_idle(input string what);
        int c;
        c = 0;
        while ((store_order.size() > 0 || outstanding > 0) && c < TEST_CYCLES) begin
            @(posedge clock);
            c++;
        end
        if (c >= TEST_CYCLES) begin
            errors++;
            $display("Timed out waiting for %s to drain", what);
        end
        repeat (3) @(posedge clock);
    endtask

    task automatic end_test(input string name);
        if (errors == errs0) begin
            pass_cnt++;
            $display("%s: ok", name);
        end else begin
            fail_cnt++;
            $display("%s: failed", name);
        end
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin : run_tests
        rob_idx_t s [8];
        rob_idx_t l [3];
        {dispatch_valid, dispatch_is_store, exec_valid, commit_valid} = '0;
        {accept0, accept1, resp_valid} = '0;
        {dispatch_idx, exec_idx, rob_head, commit_idx, resp_idx} = '0;
        {exec_addr, exec_data, resp_data} = '0;
        for (int i = 0; i < 32; i++) begin
            {load_pending[i], committed[i], ready_due[i]} = '0;
            {issue_cnt[i], wb_cnt[i]} = '0;
        end
        {outstanding, ready_cnt, stores_total, errors, pass_cnt, fail_cnt} = '0;
        next_idx = 5'd3;
        reset = 1'b1;
        repeat (8) @(posedge clock);
        reset <= 1'b0;

        start_test();
        @(negedge clock);
        assert (!wb_valid && !ready_valid && cmd0 == MEM_NONE && cmd1 == MEM_NONE && !lsq_full)
            else report_err("outputs not idle after reset");
        end_test("reset state");

        // Held dispatch counts once
        start_test();
        l[0] = next_idx++;
        load_exp[l[0]] = ~32'h100;
        dispatch(1'b0, l[0], 3);
        execute(1'b0, l[0], 32'h100, '0);
        wait_idle("held load");
        assert (issue_cnt[l[0]] == 1 && wb_cnt[l[0]] == 1)
            else report_err("held dispatch not counted once");
        end_test("duplicate dispatch");

        start_test();
        for (int i = 0; i < 3; i++) begin
            s[i] = next_idx++;
            dispatch(1'b1, s[i], 1);
        end
        for (int i = 2; i >= 0; i--) execute(1'b1, s[i], 32'h200 + 4 * i, 32'hA000_0000 + i);
        for (int i = 0; i < 3; i++) begin
            repeat (4) @(posedge clock);
            commit(s[i]);
        end
        wait_idle("store drain");
        end_test("store drain order");

        // Load after store to same word and loads from memory
        start_test();
        s[0] = next_idx++;
        dispatch(1'b1, s[0], 1);
        for (int i = 0; i < 3; i++) begin
            l[i] = next_idx++;
            load_exp[l[i]] = (i == 0) ? 32'h5EED_0001 : ~(32'h300 + 4 * i);
            dispatch(1'b0, l[i], 1);
        end
        for (int i = 2; i >= 0; i--) execute(1'b0, l[i], 32'h300 + 4 * i, '0);
        execute(1'b1, s[0], 32'h300, 32'h5EED_0001);
        commit(s[0]);
        wait_idle("load ordering");
        end_test("load data and order");

        // Full store queue stalls stores only
        start_test();
        for (int i = 0; i < 8; i++) begin
            s[i] = next_idx++;
            dispatch(1'b1, s[i], 1);
            execute(1'b1, s[i], 32'h400 + 4 * i, 32'hB000_0000 + i);
        end
        l[0] = next_idx + 5'd1;
        @(posedge clock);
        dispatch_valid <= 1'b1;
        dispatch_is_store <= 1'b1;
        dispatch_idx <= next_idx;
        @(negedge clock);
        assert (lsq_full) else report_err("stall low with store queue full");
        load_pending[l[0]] = 1'b1;
        load_exp[l[0]] = 32'hB000_0001;
        outstanding++;
        @(posedge clock);
        dispatch_is_store <= 1'b0;
        dispatch_idx <= l[0];
        @(negedge clock);
        assert (!lsq_full) else report_err("stall high for a load");
        @(posedge clock);
        dispatch_valid <= 1'b0;
        next_idx = l[0] + 5'd1;
        execute(1'b0, l[0], 32'h404, '0);
        for (int i = 0; i < 8; i++) commit(s[i]);
        wait_idle("full queue");
        end_test("store queue full");

        start_test();
        for (int i = 0; i < 32; i++) begin
            assert (!ready_due[i]) else report_err($sformatf("no ready pulse for %0d", i));
        end
        assert (ready_cnt == stores_total) else report_err("store-ready pulse count wrong");
        end_test("store ready");

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 pass_cnt + fail_cnt, pass_cnt, fail_cnt, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* project.f */
common/lsq_pkg.sv
lsq/store_queue.sv
lsq/load_queue.sv
verilog/lsq_top.sv
test/lsq_checker.sv
test/lsq_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the LSQ testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module lsq_tb -o lsq_sim > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/lsq_sim > sim.log 2>&1 \
    || { cat sim.log; echo "Simulation exited with an error"; exit 1; }

cat sim.log
grep -q "TEST FAILED" sim.log && { echo "Failure found in sim.log"; exit 1; } || exit 0
